/* sim/tb_clock.sv */
// free running clock plus the power-on reset
module tb_clock (
  output logic clk_o,
  output logic reset_o                   // high for the first 8 rising edges
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;          // 20 ns period
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;                     // released after the 8th edge is sampled
  end

endmodule

/* sim/tb_pipe_top.sv */
module tb_pipe_top import pipe_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ISSUE    = 511;              // instructions issued over all tests
  localparam int PIPE_SLOTS = 3;                // stage one, stage two, result register
  localparam int WATCHDOG   = 400 * N_ISSUE + 2000;

  logic                  clk;
  logic                  reset;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [APB_ADDR_W-1:0] paddr_i;
  logic [31:0]           pwdata_i;
  logic [31:0]           prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic                  clk_en_i;
  logic                  result_valid_o;
  logic [REG_IDX_W-1:0]  result_dest_o;
  logic [31:0]           result_value_o;
  logic                  result_ready_i;

  integer      seed = 32'h53ec_bf83;            // one stream for every random draw
  int          ready_mode = 0;                  // 0 high, 1 random, 2 low
  bit          en_mode = 1'b0;                  // random clk_en spans when set
  int          en_span = 0;
  logic [31:0] model_rf [REG_COUNT];            // reference register file
  result_t     exp_q [$];                       // results still owed by the dut
  int          taken_count = 0;
  int          mismatch_count = 0;
  int          other_count = 0;
  logic        held = 1'b0;                     // result seen stalled last edge
  result_t     held_val;
  result_t     mon_act;

  tb_clock i_tb_clock (.clk_o(clk), .reset_o(reset));
  pipe_top i_pipe_top (.*);

  // ##############################
  // checks and model
  // ##############################
  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (exp !== act)
    begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected dest=%0d value=%08h, got dest=%0d value=%08h",
               $time, name, exp.dest, exp.value, act.dest, act.value);
    end
  endtask

  task automatic check_status(input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      mismatch_count++;
      $display("mismatch at %0t: prdata_o expected %08h, got %08h", $time, exp, act);
    end
  endtask

  task automatic report(input string what);
    other_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  function automatic logic [31:0] model_alu(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    a   = model_rf[w[23:20]];
    b   = model_rf[w[19:16]];
    imm = {16'h0000, w[15:0]};                  // immediate is zero-extended
    case (w[31:28])
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      ADDI:    return a + imm;
      LUI:     return {w[15:0], 16'h0000};
      default: return 32'h0;                    // reserved codes
    endcase
  endfunction

  // in program order so write-back order matches the dut
  task automatic record_accept(input logic [31:0] w);
    result_t r;
    r.dest          = w[27:24];
    r.value         = model_alu(w);
    model_rf[r.dest] = r.value;
    exp_q.push_back(r);
  endtask

  function automatic logic [31:0] random_instr();
    logic [31:0] w;
    w = $random(seed);
    if (($random(seed) & 3) != 0)
      w[31:28] = 4'($unsigned($random(seed)) % 7); // mostly defined opcodes
    return w;
  endfunction

  // ##############################
  // apb driver
  // ##############################
  task automatic apb_access(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel_i    = 1'b1;                           // setup phase
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk);
    penable_i = 1'b1;                           // access phase
    @(posedge clk);
    rdata = prdata_o;
    err   = pslverr_o;
    if (pready_o !== 1'b1)
      report("pready_o not high in the access phase");
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic issue_instr(input logic [31:0] w);
    logic [31:0] rd;
    logic        err;
    err = 1'b1;
    while (err)
      apb_access(ADDR_INSTR, 1'b1, w, rd, err); // word dropped by a full queue goes again
    record_accept(w);
  endtask

  task automatic read_status(input int q_count);
    logic [31:0] rd;
    logic        err;
    apb_access(ADDR_STATUS, 1'b0, 32'h0, rd, err);
    if (err)
      report("status read raised pslverr");
    check_status({taken_count[15:0], 16'(q_count)}, rd);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 1000)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0)
      report("results still missing after the drain timeout");
    repeat (8) @(negedge clk);                  // any stray result shows up here
  endtask

  // ##############################
  // drivers and monitor
  // ##############################
  always @(negedge clk)
  begin
    case (ready_mode)
      0:       result_ready_i = 1'b1;
      1:       result_ready_i = 1'($random(seed)); // 50 percent
      default: result_ready_i = 1'b0;
    endcase
  end

  always @(negedge clk)
  begin
    if (!en_mode)
      clk_en_i = 1'b1;
    else if (en_span > 0)
      en_span--;
    else
    begin
      clk_en_i = !clk_en_i;                     // flip and pick a new span
      en_span  = $unsigned($random(seed)) % 10;
    end
  end

  always @(posedge clk)
  begin
    mon_act.dest  = result_dest_o;
    mon_act.value = result_value_o;
    if (reset)
      held = 1'b0;
    else
    begin
      if (!clk_en_i && result_valid_o)
        report("result offered while clock enable is low");
      if (held && result_valid_o)
        check_result("held result_dest_o/result_value_o", held_val, mon_act);
      if (held && clk_en_i && !result_valid_o)
        report("result_valid_o dropped before the result was taken");
      if (result_valid_o && result_ready_i)
      begin
        held = 1'b0;
        taken_count++;
        if (exp_q.size() == 0)
          report("unexpected result with nothing outstanding");
        else
          check_result("result_dest_o/result_value_o", exp_q.pop_front(), mon_act);
      end
      else if (result_valid_o)
      begin
        held     = 1'b1;                        // must stay put next edge
        held_val = mon_act;
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout: run hung after %0d cycles", WATCHDOG);
    $display(">>> FAIL");
    $finish;
  end

  // ##############################
  // test sequence
  // ##############################
  initial
  begin
    logic [31:0] w;
    logic [31:0] rd;
    logic        err;
    logic        exp_err;
    logic        seen_full;
    int          occ;
    psel_i         = 1'b0;
    penable_i      = 1'b0;
    pwrite_i       = 1'b0;
    paddr_i        = '0;
    pwdata_i       = '0;
    clk_en_i       = 1'b1;
    result_ready_i = 1'b0;
    for (int i = 0; i < REG_COUNT; i++)
      model_rf[i] = 32'h0;
    @(posedge clk);
    wait (reset === 1'b0);
    @(negedge clk);

    // reset state with registers reading back as zero
    if (result_valid_o !== 1'b0)
      report("result_valid_o not low after reset");
    if (pslverr_o !== 1'b0)
      report("pslverr_o not low after reset");
    read_status(0);
    w = random_instr();
    w[31:28] = OR;                              // or of two untouched registers
    issue_instr(w);
    wait_drain();

    ready_mode = 0;                             // plain stream
    repeat (200)
      issue_instr(random_instr());
    wait_drain();
    read_status(0);

    ready_mode = 1;                             // back-pressure
    repeat (200)
      issue_instr(random_instr());
    wait_drain();
    read_status(0);

    ready_mode = 2;                             // fill pipeline and queue
    repeat (4) @(negedge clk);
    seen_full = 1'b0;
    for (int i = 0; i < ISSUE_DEPTH + PIPE_SLOTS + 2; i++)
    begin
      w       = random_instr();
      exp_err = (exp_q.size() >= ISSUE_DEPTH + PIPE_SLOTS);
      apb_access(ADDR_INSTR, 1'b1, w, rd, err);
      if (exp_err && !err)
        report("pslverr missing on a write to the full queue");
      else if (!exp_err && err)
        report("pslverr on a write while the queue had room");
      if (!err)
        record_accept(w);
      else
        seen_full = 1'b1;
      repeat (3) @(negedge clk);                // word settles into its slot
      occ = exp_q.size() - PIPE_SLOTS;
      read_status((occ < 0) ? 0 : occ);
    end
    if (!seen_full)
      report("queue never reported full");
    ready_mode = 0;
    wait_drain();

    en_mode = 1'b1;                             // random freeze spans
    repeat (100)
      issue_instr(random_instr());
    en_mode = 1'b0;
    wait_drain();

    w = 32'($random(seed)) | 32'h08;            // bit 3 set so never mapped
    apb_access(w[7:0], 1'b0, 32'h0, rd, err);
    if (!err)
      report("no pslverr on a read of an unmapped address");
    apb_access(w[7:0], 1'b1, random_instr(), rd, err);
    if (!err)
      report("no pslverr on a write to an unmapped address");
    wait_drain();
    read_status(0);

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* source/apb_issue.sv */
// apb3 slave front end plus the instruction issue queue
// no wait states, every access finishes in its access phase
module apb_issue import pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  logic                  result_taken_i, // one pulse per result accepted downstream
  stage_if.src                  issue           // queue head toward decode
);

  // ############################
  // apb decode
  // ############################
  logic access;                               // access phase of any transfer
  logic addr_known;                           // address is in the map
  logic wr_instr;                             // write to the push register
  logic rd_status;                            // read of status
  logic full;                                 // no room for another word
  logic push;
  logic pop;

  logic [PTR_W-1:0]   wr_ptr;                 // next free slot
  logic [PTR_W-1:0]   rd_ptr;                 // queue head
  logic [COUNT_W-1:0] count;                  // occupancy
  logic [15:0]        result_cnt;             // results taken, wraps
  instr_u             queue_mem [ISSUE_DEPTH]; // word storage

  assign access     = psel_i && penable_i;
  assign addr_known = (paddr_i == ADDR_INSTR) || (paddr_i == ADDR_STATUS);
  assign wr_instr   = access && pwrite_i && (paddr_i == ADDR_INSTR);
  assign rd_status  = access && !pwrite_i && (paddr_i == ADDR_STATUS);
  assign full       = (count == COUNT_W'(ISSUE_DEPTH));

  assign pready_o  = 1'b1;                    // zero wait states
  assign pslverr_o = access && (!addr_known || (wr_instr && full)); // word dropped when full
  assign prdata_o  = rd_status ? {result_cnt, {(16 - COUNT_W){1'b0}}, count} : '0;

  // ############################
  // issue queue
  // ############################
  assign push = wr_instr && !full;            // no push into a full queue, even on a pop
  assign pop  = issue.valid && !issue.stall;  // head taken by decode

  assign issue.valid = (count != '0);
  assign issue.instr = queue_mem[rd_ptr];
  assign issue.op    = '0;                    // raw words only on this link

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      queue_mem[wr_ptr] <= pwdata_i;          // storage has no reset
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;                           // empty queue
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;              // wraps, depth is a power of two
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;              // both or neither
      endcase
    end
  end

  // accepted-result tally for status
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result_cnt <= '0;
    end
    else if (result_taken_i)
    begin
      result_cnt <= result_cnt + 1'b1;
    end
  end

  // occupancy bound holds across any mix of push and pop
  a_count_bound : assert property (
    @(posedge clk) disable iff (reset)
    count <= COUNT_W'(ISSUE_DEPTH)
  );

endmodule

/* source/decode_pipe.sv */
// two register stages between the queue and execute
// stage one holds the raw word, stage two the decoded op
module decode_pipe import pipe_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic clk_en_i,                   // low freezes both stages
  stage_if.dst in,                         // raw words from the queue
  stage_if.src out                         // decoded ops toward execute
);

  logic    s1_valid;                       // stage one occupied
  logic    s1_hold;                        // stage one full and blocked
  instr_u  s1_instr;                       // raw word in stage one
  logic    s2_valid;                       // stage two occupied
  logic    s2_hold;                        // stage two full and blocked
  dec_op_t s2_op;                          // decoded op in stage two
  dec_op_t dec_op;                         // decode of s1_instr

  // stall chain, each stage blocks only when full and the next one blocks
  assign s2_hold  = s2_valid && out.stall;
  assign s1_hold  = s1_valid && s2_hold;
  assign in.stall = s1_hold || !clk_en_i;  // no pop while frozen

  // ############################
  // stage one
  // ############################
  pipe_reg #(.WIDTH($bits(instr_u))) i_stage1 (
    .clk      (clk),
    .reset    (reset),
    .stall_i  (s1_hold),
    .clk_en_i (clk_en_i),
    .data_i   (in.instr),
    .data_o   (s1_instr)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      s1_valid <= 1'b0;
    end
    else if (clk_en_i && !s1_hold)
    begin
      s1_valid <= in.valid;                // bubble when queue is empty
    end
  end

  // view of the union follows the opcode
  always_comb
  begin
    dec_op        = '0;
    dec_op.opcode = s1_instr.rtype.opcode; // same bits in both views
    dec_op.dest   = s1_instr.rtype.dest;
    dec_op.src_a  = s1_instr.rtype.src_a;
    case (s1_instr.rtype.opcode)
      ADDI, LUI:
      begin
        dec_op.b_is_imm = 1'b1;
        dec_op.imm      = {16'h0000, s1_instr.itype.imm}; // zero-extend
      end
      default:
      begin
        dec_op.b_is_imm = 1'b0;            // register form, reserved too
        dec_op.src_b    = s1_instr.rtype.src_b;
      end
    endcase
  end

  // ############################
  // stage two
  // ############################
  pipe_reg #(.WIDTH($bits(dec_op_t))) i_stage2 (
    .clk      (clk),
    .reset    (reset),
    .stall_i  (s2_hold),
    .clk_en_i (clk_en_i),
    .data_i   (dec_op),
    .data_o   (s2_op)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      s2_valid <= 1'b0;
    end
    else if (clk_en_i && !s2_hold)
    begin
      s2_valid <= s1_valid;
    end
  end

  assign out.valid = s2_valid;
  assign out.op    = s2_op;
  assign out.instr = '0;                   // only decoded ops past here

  // held op must not change under a stall from execute
  a_out_stable : assert property (
    @(posedge clk) disable iff (reset)
    out.valid && out.stall |=> out.valid && $stable(out.op)
  );

endmodule

/* source/execute_unit.sv */
// register file, alu and result register
// write-back and result load share one edge, so no forwarding is needed
module execute_unit import pipe_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    clk_en_i,                // low freezes every register here
  stage_if.dst    in,                      // decoded ops
  output result_t result_o,
  output logic    result_valid_o,
  input  logic    result_ready_i,
  output logic    result_taken_o           // pulse toward the status tally
);

  logic [31:0] reg_file [REG_COUNT];       // architectural registers
  logic [31:0] op_a;                       // operand a
  logic [31:0] op_b;                       // operand b, register or imm
  logic [31:0] alu_out;
  logic        full_q;                     // result register occupied
  logic        fire;                       // op accepted this edge
  result_t     result_q;                   // held result

  // ############################
  // operands and alu
  // ############################
  assign op_a = reg_file[in.op.src_a];
  assign op_b = in.op.b_is_imm ? in.op.imm : reg_file[in.op.src_b];

  always_comb
  begin
    case (in.op.opcode)
      ADD, ADDI: alu_out = op_a + op_b;
      SUB:       alu_out = op_a - op_b;
      AND:       alu_out = op_a & op_b;
      OR:        alu_out = op_a | op_b;
      XOR:       alu_out = op_a ^ op_b;
      LUI:       alu_out = {op_b[15:0], 16'h0000}; // imm into upper half
      default:   alu_out = '0;             // reserved opcodes
    endcase
  end

  // ############################
  // handshake
  // ############################
  assign result_valid_o = full_q && clk_en_i;         // nothing offered while frozen
  assign result_taken_o = result_valid_o && result_ready_i;
  assign in.stall       = (full_q && !result_taken_o) || !clk_en_i;
  assign fire           = in.valid && !in.stall;      // empty or draining this edge
  assign result_o       = result_q;

  // write-back, register file cleared on reset
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < REG_COUNT; i++)
      begin
        reg_file[i] <= '0;
      end
    end
    else if (fire)
    begin
      reg_file[in.op.dest] <= alu_out;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      full_q <= 1'b0;
    end
    else if (fire)
    begin
      full_q <= 1'b1;                      // refill, also when taken same edge
    end
    else if (result_taken_o)
    begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      result_q.dest  <= in.op.dest;
      result_q.value <= alu_out;
    end
  end

  // a held result stays put until the consumer takes it
  a_result_held : assert property (
    @(posedge clk) disable iff (reset)
    full_q && !result_taken_o |=> full_q && $stable(result_q)
  );

endmodule

/* source/pipe_pkg.sv */
package pipe_pkg;

  // ############################
  // sizes and address map
  // ############################
  localparam int ISSUE_DEPTH = 4;                      // issue queue entries
  localparam int PTR_W       = $clog2(ISSUE_DEPTH);    // queue pointer width
  localparam int COUNT_W     = $clog2(ISSUE_DEPTH + 1); // occupancy 0..ISSUE_DEPTH
  localparam int REG_COUNT   = 16;                     // architectural registers
  localparam int REG_IDX_W   = $clog2(REG_COUNT);      // register index width
  localparam int APB_ADDR_W  = 8;                      // apb address bus width

  localparam logic [APB_ADDR_W-1:0] ADDR_INSTR  = 8'h00; // wo, push word into queue
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h04; // ro, count and result tally

  // ############################
  // instruction encoding
  // ############################
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    ADDI = 4'h5,                     // immediate view
    LUI  = 4'h6                      // immediate view, imm lands in upper half
  } opcode_t;                        // codes 7..15 reserved, result is zero

  typedef struct packed {
    opcode_t               opcode;   // [31:28]
    logic [REG_IDX_W-1:0]  dest;     // [27:24]
    logic [REG_IDX_W-1:0]  src_a;    // [23:20]
    logic [REG_IDX_W-1:0]  src_b;    // [19:16]
    logic [15:0]           unused;   // [15:0] ignored
  } instr_reg_t;

  typedef struct packed {
    opcode_t               opcode;   // [31:28]
    logic [REG_IDX_W-1:0]  dest;     // [27:24]
    logic [REG_IDX_W-1:0]  src_a;    // [23:20]
    logic [3:0]            pad;      // [19:16] ignored
    logic [15:0]           imm;      // [15:0] zero-extended
  } instr_imm_t;

  // one 32-bit word, two readings picked by the opcode
  typedef union packed {
    instr_reg_t rtype;
    instr_imm_t itype;
  } instr_u;

  // ############################
  // decoded op and result
  // ############################
  typedef struct packed {
    opcode_t               opcode;
    logic [REG_IDX_W-1:0]  dest;
    logic [REG_IDX_W-1:0]  src_a;
    logic                  b_is_imm; // 1 = operand b from imm, 0 = from src_b
    logic [REG_IDX_W-1:0]  src_b;
    logic [31:0]           imm;      // already zero-extended
  } dec_op_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0]  dest;
    logic [31:0]           value;
  } result_t;

endpackage

/* source/pipe_reg.sv */
// generic stage register
// loads only when not stalled and clock enable is high, else holds
module pipe_reg #(
  parameter int WIDTH = 32                 // payload width
) (
  input  logic             clk,
  input  logic             reset,          // sync, clears the stage
  input  logic             stall_i,        // downstream cannot take, hold
  input  logic             clk_en_i,       // low freezes the stage like a gated clock
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  logic [WIDTH-1:0] data_q;                // stage contents

  assign data_o = data_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      data_q <= '0;                        // cleared stage
    end
    else if (!stall_i && clk_en_i)
    begin
      data_q <= data_i;                    // advance
    end
  end

endmodule

/* source/pipe_top.sv */
// top level, queue then decode then execute
module pipe_top import pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  // apb slave
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // stage freeze
  input  logic                  clk_en_i,
  // result stream
  output logic                  result_valid_o,
  output logic [REG_IDX_W-1:0]  result_dest_o,
  output logic [31:0]           result_value_o,
  input  logic                  result_ready_i
);

  result_t result;                         // packed result from execute
  logic    result_taken;                   // feeds the status tally

  stage_if issue_link ();                  // queue head to decode
  stage_if exec_link ();                   // decode to execute

  apb_issue i_apb_issue (
    .clk            (clk),
    .reset          (reset),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .result_taken_i (result_taken),
    .issue          (issue_link.src)
  );

  decode_pipe i_decode_pipe (
    .clk      (clk),
    .reset    (reset),
    .clk_en_i (clk_en_i),
    .in       (issue_link.dst),
    .out      (exec_link.src)
  );

  execute_unit i_execute_unit (
    .clk            (clk),
    .reset          (reset),
    .clk_en_i       (clk_en_i),
    .in             (exec_link.dst),
    .result_o       (result),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_taken_o (result_taken)
  );

  assign result_dest_o  = result.dest;     // split for plain ports
  assign result_value_o = result.value;

endmodule

/* source/stage_if.sv */
// handshake between two pipeline stages
// transfer happens on an edge with valid high and stall low
interface stage_if import pipe_pkg::*; ();

  logic    valid;  // source has something for the receiver
  instr_u  instr;  // raw word, used on the queue to decode link
  dec_op_t op;     // decoded op, used on the decode to execute link
  logic    stall;  // receiver cannot take it, from receiver state only

  // sending side holds valid and payload while stall is high
  modport src (
    output valid,
    output instr,
    output op,
    input  stall
  );

  modport dst (
    input  valid,
    input  instr,
    input  op,
    output stall
  );

endinterface

/* verilog.f */
source/pipe_pkg.sv
source/stage_if.sv
source/pipe_reg.sv
source/apb_issue.sv
source/decode_pipe.sv
source/execute_unit.sv
source/pipe_top.sv
sim/tb_clock.sv
sim/tb_pipe_top.sv
